// ==== hdl/uop_pkg.sv ====
package uop_pkg;

    // ROM geometry
    localparam int ROM_ADDR_W = 6;
    localparam int ROM_ROWS   = 1 << ROM_ADDR_W;

    // Defaults for the top-level parameters
    localparam int DE_DEPTH_DEF   = 2;
    localparam int RN_CREDITS_DEF = 4;

    // Row index into the microcode ROM
    typedef logic [ROM_ADDR_W-1:0] t_rom_addr;

    // Plain micro-op, trap bit clear
    typedef struct packed {
        logic       trap;
        logic       eom;      // last uop of the macro
        logic [7:0] opcode;
        logic [4:0] dst;
        logic [4:0] src1;
        logic [4:0] src2;
        logic [6:0] imm;
    } t_uop_normal;

    // Trap-to-microcode op, trap bit set
    typedef struct packed {
        logic       trap;
        logic       pad;
        t_rom_addr  rom_addr;   // first ROM row of the flow
        logic [23:0] code;      // rides along, sequencer ignores it
    } t_uop_trap;

    // Top bit picks the view
    typedef union packed {
        t_uop_normal normal;
        t_uop_trap   trap;
    } t_uop_word;

endpackage

// ==== hdl/ucode_rom.sv ====
`timescale 1ns/1ps

module ucode_rom (
    input  uop_pkg::t_rom_addr rom_addr,
    output uop_pkg::t_uop_word rom_word
);

    // Stand-in microcode, one normal uop per row
    uop_pkg::t_uop_word rom_table [uop_pkg::ROM_ROWS];

    // Row contents derived from the row index
    function automatic uop_pkg::t_uop_word rom_row(input uop_pkg::t_rom_addr r);
        uop_pkg::t_uop_word w;
        w = '0;
        w.normal.trap   = 1'b0;
        w.normal.opcode = 8'(r);
        w.normal.dst    = {1'b0, r[3:0]};
        w.normal.src1   = {1'b0, ~r[3:0]};
        // Flow ends every eight rows
        // and always at the last row
        w.normal.eom    = (r[2:0] == 3'b111)
                       || (r == uop_pkg::t_rom_addr'(uop_pkg::ROM_ROWS - 1));
        return w;
    endfunction

    // Fill the whole table
    always_comb begin
        for (int i = 0; i < uop_pkg::ROM_ROWS; i++) begin
            rom_table[i] = rom_row(uop_pkg::t_rom_addr'(i));
        end
    end

    // Asynchronous row read
    assign rom_word = rom_table[rom_addr];

endmodule

// ==== hdl/decode_queue.sv ====
`timescale 1ns/1ps

module decode_queue #(
    parameter int DE_DEPTH = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               nuke,
    input  logic               in_valid,
    input  uop_pkg::t_uop_word in_word,
    output logic               in_credit,
    output logic               head_valid,
    output uop_pkg::t_uop_word head_word,
    input  logic               head_pop
);

    localparam int PTR_W = (DE_DEPTH > 1) ? $clog2(DE_DEPTH) : 1;
    localparam int CNT_W = $clog2(DE_DEPTH + 1);

    uop_pkg::t_uop_word mem [DE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;
    logic             credit_q;

    // Wrap at DE_DEPTH, not at a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(DE_DEPTH));
    assign push       = in_valid & ~full & ~nuke;
    assign pop        = head_pop & head_valid;
    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];
    assign in_credit  = credit_q;

    // Pointers, occupancy, credit return
    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            // Flushed entries never return credits
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit per pop, a cycle later
            credit_q <= pop;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

endmodule

// ==== hdl/rename_credit.sv ====
`timescale 1ns/1ps

module rename_credit #(
    parameter int RN_CREDITS = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic send,
    input  logic rn_credit,
    output logic can_send
);

    localparam int CNT_W = $clog2(RN_CREDITS + 1);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             at_max;
    logic             at_zero;

    assign at_max  = (count == CNT_W'(RN_CREDITS));
    assign at_zero = (count == '0);

    // Free rename slots left
    assign can_send = ~at_zero;

    // Up/down with saturation at both ends
    always_comb begin
        count_nxt = count;
        case ({send, rn_credit})
            2'b10: begin
                if (!at_zero) begin
                    count_nxt = count - 1'b1;
                end
            end
            2'b01: begin
                // Spurious extra credits are dropped
                if (!at_max) begin
                    count_nxt = count + 1'b1;
                end
            end
            // Send and return cancel out
            default: count_nxt = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Rename starts fully open
            count <= CNT_W'(RN_CREDITS);
        end else begin
            count <= count_nxt;
        end
    end

endmodule

// ==== hdl/ucode_seq.sv ====
`timescale 1ns/1ps

module ucode_seq (
    input  logic               clk,
    input  logic               reset,
    input  logic               nuke,
    input  logic               head_valid,
    input  uop_pkg::t_uop_word head_word,
    output logic               head_pop,
    input  logic               can_send,
    output logic               send,
    output uop_pkg::t_rom_addr rom_addr,
    input  uop_pkg::t_uop_word rom_word,
    output logic               out_valid,
    output uop_pkg::t_uop_word out_word
);

    typedef enum logic {
        UC_IDLE,
        UC_FETCH
    } t_uc_fsm;

    t_uc_fsm            fsm;
    t_uc_fsm            fsm_nxt;
    uop_pkg::t_rom_addr useq_pc;
    uop_pkg::t_rom_addr useq_pc_nxt;
    logic               head_is_trap;

    // Top bit sits in the same place in both views
    assign head_is_trap = head_word.trap.trap;

    // ROM is always addressed by the program counter
    assign rom_addr = useq_pc;

    // Output steering
    always_comb begin
        out_valid = 1'b0;
        out_word  = head_word;
        head_pop  = 1'b0;
        case (fsm)
            UC_IDLE: begin
                // Normal uops go straight through
                out_valid = head_valid & ~head_is_trap & can_send;
                head_pop  = out_valid;
            end
            UC_FETCH: begin
                out_valid = can_send;
                out_word  = rom_word;
                // Trap retires with its last row
                head_pop  = can_send & rom_word.normal.eom;
            end
            default: begin
                out_valid = 1'b0;
            end
        endcase
    end

    assign send = out_valid;

    // Next state and program counter
    always_comb begin
        fsm_nxt     = fsm;
        useq_pc_nxt = useq_pc;
        case (fsm)
            UC_IDLE: begin
                if (head_valid && head_is_trap) begin
                    fsm_nxt     = UC_FETCH;
                    useq_pc_nxt = head_word.trap.rom_addr;
                end
            end
            UC_FETCH: begin
                // Holds under rename back-pressure
                if (send) begin
                    useq_pc_nxt = useq_pc + 1'b1;
                end
                if (head_pop) begin
                    fsm_nxt = UC_IDLE;
                end
            end
            default: fsm_nxt = UC_IDLE;
        endcase
        // Flush abandons any flow in progress
        if (nuke) begin
            fsm_nxt = UC_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fsm     <= UC_IDLE;
            useq_pc <= '0;
        end else begin
            fsm     <= fsm_nxt;
            useq_pc <= useq_pc_nxt;
        end
    end

endmodule

// ==== hdl/frontend_ucode_top.sv ====
`timescale 1ns/1ps

module frontend_ucode_top #(
    parameter int DE_DEPTH   = uop_pkg::DE_DEPTH_DEF,
    parameter int RN_CREDITS = uop_pkg::RN_CREDITS_DEF
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               nuke,
    input  logic               in_valid,
    input  uop_pkg::t_uop_word in_word,
    output logic               in_credit,
    output logic               out_valid,
    output uop_pkg::t_uop_word out_word,
    input  logic               rn_credit
);

    // Queue head toward the sequencer
    logic               head_valid;
    uop_pkg::t_uop_word head_word;
    logic               head_pop;

    // ROM lookup
    uop_pkg::t_rom_addr rom_addr;
    uop_pkg::t_uop_word rom_word;

    // Rename slot tracking
    logic               send;
    logic               can_send;

    decode_queue #(
        .DE_DEPTH   (DE_DEPTH)
    ) u_decode_queue (
        .clk        (clk),
        .reset      (reset),
        .nuke       (nuke),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_credit  (in_credit),
        .head_valid (head_valid),
        .head_word  (head_word),
        .head_pop   (head_pop)
    );

    ucode_seq u_ucode_seq (
        .clk        (clk),
        .reset      (reset),
        .nuke       (nuke),
        .head_valid (head_valid),
        .head_word  (head_word),
        .head_pop   (head_pop),
        .can_send   (can_send),
        .send       (send),
        .rom_addr   (rom_addr),
        .rom_word   (rom_word),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

    ucode_rom u_ucode_rom (
        .rom_addr   (rom_addr),
        .rom_word   (rom_word)
    );

    rename_credit #(
        .RN_CREDITS (RN_CREDITS)
    ) u_rename_credit (
        .clk        (clk),
        .reset      (reset),
        .send       (send),
        .rn_credit  (rn_credit),
        .can_send   (can_send)
    );

endmodule

// ==== testbench/tb_frontend_ucode_tasks.svh ====
// Move to the drive point of the next cycle
task automatic step_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
endtask

task automatic check_word(input string name, input uop_pkg::t_uop_word expected,
                          input uop_pkg::t_uop_word actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        err_count++;
    end
endtask

task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        err_count++;
    end
endtask

task automatic begin_test(input string name);
    cur_test = name;
    err_base = err_count;
endtask

task automatic end_test();
    if (err_count == err_base) begin
        tests_passed++;
        $display("PASS %s", cur_test);
    end else begin
        tests_failed++;
        $display("FAIL %s with %0d errors", cur_test, err_count - err_base);
    end
endtask

// One word from the source spends a credit
task automatic push_word(input uop_pkg::t_uop_word w);
    while (src_credits == 0) begin
        step_cycle();
    end
    src_credits--;
    in_valid = 1'b1;
    in_word  = w;
    step_cycle();
    in_valid = 1'b0;
    in_word  = '0;
endtask

// Until every expected word has come out
task automatic wait_outputs();
    while (exp_q.size() != 0) begin
        step_cycle();
    end
endtask

// Also let rename slots and source credits settle
task automatic wait_idle();
    wait_outputs();
    while (rn_pending != 0) begin
        step_cycle();
    end
    repeat (3) step_cycle();
endtask

function automatic uop_pkg::t_uop_word rand_normal();
    uop_pkg::t_uop_word w;
    w = $urandom();
    w.normal.trap = 1'b0;
    return w;
endfunction

function automatic uop_pkg::t_uop_word make_trap(input int addr);
    uop_pkg::t_uop_word w;
    w = '0;
    w.trap.trap     = 1'b1;
    w.trap.rom_addr = uop_pkg::t_rom_addr'(addr);
    w.trap.code     = 24'($urandom());
    return w;
endfunction

// Row r of the microcode table
function automatic uop_pkg::t_uop_word rom_row_model(input int r);
    uop_pkg::t_uop_word w;
    w = '0;
    w.normal.opcode = 8'(r);
    w.normal.dst    = 5'(r % 16);
    w.normal.src1   = 5'(15 - (r % 16));
    // Every eighth row ends a flow and so does the last row
    w.normal.eom    = ((r % 8) == 7) || (r == 63);
    return w;
endfunction

// Queue the rows of one flow up to its end marker
task automatic expect_flow(input int start);
    uop_pkg::t_uop_word w;
    int r;
    r = start;
    do begin
        w = rom_row_model(r);
        exp_q.push_back(w);
        r++;
    end while (!w.normal.eom);
endtask

task automatic test_reset();
    int out_base;
    int cr_base;
    begin_test("test_reset");
    out_base = out_count;
    cr_base  = credit_pulses;
    repeat (6) step_cycle();
    check_count(cur_test, 0, out_count - out_base);
    check_count(cur_test, 0, credit_pulses - cr_base);
    end_test();
endtask

task automatic test_passthrough();
    uop_pkg::t_uop_word w;
    int cr_base;
    begin_test("test_passthrough");
    cr_base = credit_pulses;
    rn_auto = 1'b1;
    for (int i = 0; i < 12; i++) begin
        w = rand_normal();
        exp_q.push_back(w);
        push_word(w);
    end
    wait_idle();
    check_count(cur_test, 12, credit_pulses - cr_base);
    end_test();
endtask

task automatic test_ucode_expand();
    uop_pkg::t_uop_word w;
    int out_base;
    begin_test("test_ucode_expand");
    out_base = out_count;
    rn_auto  = 1'b1;
    // Rows 3 to 7, 8 to 15 and 60 to 63
    expect_flow(3);
    push_word(make_trap(3));
    expect_flow(8);
    push_word(make_trap(8));
    expect_flow(60);
    push_word(make_trap(60));
    // Normal word waits behind the last flow
    w = rand_normal();
    exp_q.push_back(w);
    push_word(w);
    wait_idle();
    check_count(cur_test, 18, out_count - out_base);
    end_test();
endtask

task automatic test_rename_backpressure();
    uop_pkg::t_uop_word w;
    int out_base;
    begin_test("test_rename_backpressure");
    out_base = out_count;
    rn_auto  = 1'b0;
    for (int i = 0; i < 6; i++) begin
        w = rand_normal();
        exp_q.push_back(w);
        push_word(w);
    end
    repeat (8) step_cycle();
    check_count(cur_test, RN_CREDITS, out_count - out_base);
    rn_auto = 1'b1;
    wait_idle();
    check_count(cur_test, 6, out_count - out_base);
    end_test();
endtask

task automatic test_source_credits();
    uop_pkg::t_uop_word w;
    int out_base;
    int cr_base;
    begin_test("test_source_credits");
    out_base = out_count;
    cr_base  = credit_pulses;
    rn_auto  = 1'b0;
    // Four go to rename and then the queue fills
    for (int i = 0; i < RN_CREDITS + DE_DEPTH; i++) begin
        w = rand_normal();
        exp_q.push_back(w);
        push_word(w);
    end
    check_count(cur_test, 0, src_credits);
    repeat (6) step_cycle();
    // Only the words taken by rename have been popped
    check_count(cur_test, RN_CREDITS, out_count - out_base);
    check_count(cur_test, RN_CREDITS, credit_pulses - cr_base);
    rn_auto = 1'b1;
    wait_idle();
    check_count(cur_test, RN_CREDITS + DE_DEPTH, credit_pulses - cr_base);
    check_count(cur_test, DE_DEPTH, src_credits);
    end_test();
endtask

task automatic test_nuke();
    uop_pkg::t_uop_word w;
    int out_base;
    int cr_base;
    begin_test("test_nuke");
    out_base = out_count;
    cr_base  = credit_pulses;
    rn_auto  = 1'b0;
    // Flow from row 8 stalls after four rows
    for (int r = 8; r < 8 + RN_CREDITS; r++) begin
        exp_q.push_back(rom_row_model(r));
    end
    push_word(make_trap(8));
    wait_outputs();
    repeat (3) step_cycle();
    nuke = 1'b1;
    step_cycle();
    nuke        = 1'b0;
    src_credits = DE_DEPTH;
    rn_auto     = 1'b1;
    // Slots come back but the flow is gone
    repeat (6) step_cycle();
    check_count(cur_test, RN_CREDITS, out_count - out_base);
    check_count(cur_test, 0, credit_pulses - cr_base);
    w = rand_normal();
    exp_q.push_back(w);
    push_word(w);
    wait_idle();
    check_count(cur_test, RN_CREDITS + 1, out_count - out_base);
    end_test();
endtask

// ==== testbench/tb_frontend_ucode.sv ====
`timescale 1ns/1ps

module tb_frontend_ucode;

    localparam int DE_DEPTH    = uop_pkg::DE_DEPTH_DEF;
    localparam int RN_CREDITS  = uop_pkg::RN_CREDITS_DEF;
    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 10;
    // All six tests together take a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk;
    logic               reset;
    logic               nuke;
    logic               in_valid;
    uop_pkg::t_uop_word in_word;
    logic               in_credit;
    logic               out_valid;
    uop_pkg::t_uop_word out_word;
    logic               rn_credit;

    // Words still owed by the DUT, oldest first
    uop_pkg::t_uop_word exp_q [$];

    // Source and rename side models
    int    src_credits;
    int    rn_pending;
    bit    rn_auto;

    // Running counts
    int    out_count;
    int    credit_pulses;
    int    err_count;
    int    err_base;
    int    tests_passed;
    int    tests_failed;
    int    cycles;
    string cur_test;

    frontend_ucode_top #(
        .DE_DEPTH   (DE_DEPTH),
        .RN_CREDITS (RN_CREDITS)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .nuke       (nuke),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .rn_credit  (rn_credit)
    );

    `include "tb_frontend_ucode_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Rename returns one slot per cycle while allowed
    initial begin
        bit give;
        rn_credit = 1'b0;
        forever begin
            @(posedge clk);
            give = rn_auto && (rn_pending > 0);
            if (give) begin
                rn_pending--;
            end
            #(DRIVE_DELAY);
            rn_credit = give;
        end
    end

    // Outputs sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                out_count++;
                rn_pending++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected output word %h during %s", out_word, cur_test);
                    err_count++;
                end else begin
                    check_word(cur_test, exp_q.pop_front(), out_word);
                end
            end
            if (in_credit) begin
                credit_pulses++;
                src_credits++;
                if (src_credits > DE_DEPTH) begin
                    $display("Source got more credits back than the queue holds in %s",
                             cur_test);
                    err_count++;
                end
            end
        end
    end

    // Hang guard
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h75a76385));
        reset         = 1'b1;
        nuke          = 1'b0;
        in_valid      = 1'b0;
        in_word       = '0;
        src_credits   = DE_DEPTH;
        rn_pending    = 0;
        rn_auto       = 1'b1;
        out_count     = 0;
        credit_pulses = 0;
        err_count     = 0;
        err_base      = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cur_test      = "reset";
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        test_reset();
        test_passthrough();
        test_ucode_expand();
        test_rename_backpressure();
        test_source_credits();
        test_nuke();

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+testbench
hdl/uop_pkg.sv
hdl/ucode_rom.sv
hdl/decode_queue.sv
hdl/rename_credit.sv
hdl/ucode_seq.sv
hdl/frontend_ucode_top.sv
testbench/tb_frontend_ucode.sv

// ==== Bender.yml ====
package:
  name: frontend_ucode

sources:
  - hdl/uop_pkg.sv
  - hdl/ucode_rom.sv
  - hdl/decode_queue.sv
  - hdl/rename_credit.sv
  - hdl/ucode_seq.sv
  - hdl/frontend_ucode_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_frontend_ucode.sv
